// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_pgwr_mngr
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

sim: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "NO ERRORS" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== common/pgwr_pkg.sv ====
//--------------------------------------------------------------------------
// shared definitions of the page write manager: line and bus geometry,
// table base addresses, ATT and list entry layouts, lane union, write kinds
//--------------------------------------------------------------------------

package pgwr_pkg;

	// line and bus geometry
	localparam int LINE_BYTES = 64;
	localparam int DATA_W = LINE_BYTES * 8;   // 512
	localparam int STRB_W = LINE_BYTES;       // one strobe per byte
	localparam int ADDR_W = 64;

	// table placement in memory
	localparam logic [ADDR_W-1:0] ATT_BASE = 64'h0000_0000_8000_0000;
	localparam logic [ADDR_W-1:0] LIST_BASE = 64'h0000_0000_8001_0000;

	// list entry k owns physical page PPA_BASE_PG + k - 1
	localparam logic [45:0] PPA_BASE_PG = 46'h0000_0008_0100;

	localparam int ID_W = 32;   // id 0 is the null pointer

	// page status held in the low bits of an ATT entry
	typedef enum logic [1:0] {
		DALLOC = 2'd0,
		ALLOC = 2'd1,
		UNCOMP = 2'd2
	} sts_e;

	typedef struct packed {
		logic [15:0] zpd_cnt;   // zero page count
		logic [45:0] way;       // physical page number
		sts_e sts;
	} att_entry_t;

	// low lane of a 128-bit list entry, prev above next
	typedef struct packed {
		logic [ID_W-1:0] prev;
		logic [ID_W-1:0] next;
	} ptr_pair_t;

	// one 64-bit lane of a line, read as ATT entry or list pointers
	typedef union packed {
		att_entry_t att;
		ptr_pair_t ptr;
	} tbl_lane_u;

	// kind of table write the sequencer asks for
	typedef enum logic [2:0] {
		ATT_INIT = 3'd0,
		LIST_INIT = 3'd1,
		ATT_ALLOC = 3'd2,
		POP_FIX = 3'd3,     // new free head gets prev = null
		PUSH_SELF = 3'd4,   // pushed entry gets prev = old tail, next = null
		PUSH_LINK = 3'd5    // old tail gets next = pushed id
	} step_e;

endpackage

// ==== flist.f ====
common/pgwr_pkg.sv
logic/axi_wr_port.sv
pgwr_mngr/list_ptr_regs.sv
pgwr_mngr/tbl_wr_fmt.sv
pgwr_mngr/pgwr_seq.sv
pgwr_mngr/pgwr_mngr.sv
testbench/tb_wr_slave.sv
testbench/tb_pgwr_mngr.sv

// ==== logic/axi_wr_port.sv ====
//--------------------------------------------------------------------------
// single write channel port: request register, address then data beat,
// outstanding response count and sticky bus error
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module axi_wr_port (
	input logic clk_i,
	input logic rst_ni,
	input logic issue,
	input logic [pgwr_pkg::ADDR_W-1:0] addr,
	input logic [pgwr_pkg::DATA_W-1:0] data,
	input logic [pgwr_pkg::STRB_W-1:0] strb,
	input logic awready,
	input logic wready,
	input logic bvalid,
	input logic [1:0] bresp,
	output logic awvalid,
	output logic [pgwr_pkg::ADDR_W-1:0] awaddr,
	output logic wvalid,
	output logic [pgwr_pkg::DATA_W-1:0] wdata,
	output logic [pgwr_pkg::STRB_W-1:0] wstrb,
	output logic wr_idle,
	output logic resp_idle,
	output logic bus_error
);

	localparam int CNT_W = 4;

	logic [CNT_W-1:0] out_cnt;   // responses still owed
	logic aw_beat;
	logic w_beat;

	assign aw_beat = awvalid && awready;
	assign w_beat = wvalid && wready;
	// idle already in the cycle of the data beat
	assign wr_idle = !awvalid && (!wvalid || wready);
	assign resp_idle = (out_cnt == '0);

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			awvalid <= 1'b0;
			wvalid <= 1'b0;
		end else begin
			if (aw_beat) begin
				awvalid <= 1'b0;
				wvalid <= 1'b1;   // data follows the address
			end else if (issue) begin
				awvalid <= 1'b1;
			end
			if (w_beat) wvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk_i) begin
		if (issue) begin
			awaddr <= addr;
			wdata <= data;
			wstrb <= strb;
		end
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			out_cnt <= '0;
			bus_error <= 1'b0;
		end else begin
			if (aw_beat && !bvalid) out_cnt <= out_cnt + 1'b1;
			else if (!aw_beat && bvalid && out_cnt != '0) out_cnt <= out_cnt - 1'b1;
			// error status, or response nobody waits for
			if (bvalid && (bresp != 2'b00 || out_cnt == '0)) bus_error <= 1'b1;
		end
	end

	a_aw_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
		awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(wdata) && $stable(wstrb));

endmodule

// ==== pgwr_mngr/list_ptr_regs.sv ====
//--------------------------------------------------------------------------
// free and uncompressed list head/tail registers, init done flags
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module list_ptr_regs (
	input logic clk_i,
	input logic rst_ni,
	input logic free_set,
	input logic [pgwr_pkg::ID_W-1:0] free_head_nxt,
	input logic [pgwr_pkg::ID_W-1:0] free_tail_nxt,
	input logic uncomp_set,
	input logic [pgwr_pkg::ID_W-1:0] uncomp_head_nxt,
	input logic [pgwr_pkg::ID_W-1:0] uncomp_tail_nxt,
	input logic set_att_done,
	input logic set_list_done,
	output logic [pgwr_pkg::ID_W-1:0] free_head,
	output logic [pgwr_pkg::ID_W-1:0] free_tail,
	output logic [pgwr_pkg::ID_W-1:0] uncomp_head,
	output logic [pgwr_pkg::ID_W-1:0] uncomp_tail,
	output logic att_done,
	output logic list_done
);

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			free_head <= '0;   // all lists empty
			free_tail <= '0;
			uncomp_head <= '0;
			uncomp_tail <= '0;
			att_done <= 1'b0;
			list_done <= 1'b0;
		end else begin
			if (free_set) begin
				free_head <= free_head_nxt;
				free_tail <= free_tail_nxt;
			end
			if (uncomp_set) begin
				uncomp_tail <= uncomp_tail_nxt;
				if (uncomp_tail == '0) uncomp_head <= uncomp_head_nxt;   // first push only
			end
			if (set_att_done) att_done <= 1'b1;    // sticky
			if (set_list_done) list_done <= 1'b1;
		end
	end

	// uncompressed list is either empty or has both ends
	a_uncomp_ends: assert property (@(posedge clk_i) disable iff (!rst_ni)
		(uncomp_head == '0) == (uncomp_tail == '0));

endmodule

// ==== pgwr_mngr/pgwr_mngr.sv ====
//--------------------------------------------------------------------------
// page write manager top: sequencer, table write formatter,
// list pointer registers and single write channel port
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module pgwr_mngr #(
	parameter int ATT_ENTRY_CNT = 16,
	parameter int LIST_ENTRY_CNT = 8
) (
	input logic clk_i,
	input logic rst_ni,
	input logic init_att,
	input logic init_list,
	input logic upd_valid,
	input logic [pgwr_pkg::ID_W-1:0] upd_att_id,
	input logic [pgwr_pkg::ID_W-1:0] upd_next,    // next of the current free head
	input logic awready,
	input logic wready,
	input logic bvalid,
	input logic [1:0] bresp,
	output logic awvalid,
	output logic [pgwr_pkg::ADDR_W-1:0] awaddr,
	output logic wvalid,
	output logic [pgwr_pkg::DATA_W-1:0] wdata,
	output logic [pgwr_pkg::STRB_W-1:0] wstrb,
	output logic upd_ready,
	output logic upd_done,
	output logic att_done,
	output logic list_done,
	output logic ready,
	output logic bus_error,
	output logic [pgwr_pkg::ID_W-1:0] free_head,   // pointers seen by the read manager
	output logic [pgwr_pkg::ID_W-1:0] free_tail,
	output logic [pgwr_pkg::ID_W-1:0] uncomp_head,
	output logic [pgwr_pkg::ID_W-1:0] uncomp_tail
);

	logic issue;
	pgwr_pkg::step_e step;
	logic [pgwr_pkg::ID_W-1:0] entry_id;
	logic [pgwr_pkg::ID_W-1:0] ptr_arg;
	logic [pgwr_pkg::ADDR_W-1:0] req_addr;
	logic [pgwr_pkg::DATA_W-1:0] req_data;
	logic [pgwr_pkg::STRB_W-1:0] req_strb;
	logic wr_idle;
	logic resp_idle;
	logic set_att_done;
	logic set_list_done;
	logic free_set;
	logic uncomp_set;
	logic [pgwr_pkg::ID_W-1:0] free_head_nxt;
	logic [pgwr_pkg::ID_W-1:0] free_tail_nxt;
	logic [pgwr_pkg::ID_W-1:0] uncomp_head_nxt;
	logic [pgwr_pkg::ID_W-1:0] uncomp_tail_nxt;

	pgwr_seq #(
		.ATT_ENTRY_CNT(ATT_ENTRY_CNT),
		.LIST_ENTRY_CNT(LIST_ENTRY_CNT)
	) u_seq (
		.clk_i, .rst_ni, .init_att, .init_list, .upd_valid, .upd_att_id, .upd_next,
		.att_done, .list_done, .free_head, .free_tail, .uncomp_tail,
		.wr_idle, .resp_idle, .upd_ready, .upd_done, .ready,
		.issue, .step, .entry_id, .ptr_arg, .set_att_done, .set_list_done,
		.free_set, .free_head_nxt, .free_tail_nxt,
		.uncomp_set, .uncomp_head_nxt, .uncomp_tail_nxt
	);

	// free_head is still the pushed id while ATT_ALLOC is formed
	tbl_wr_fmt #(
		.ATT_ENTRY_CNT(ATT_ENTRY_CNT),
		.LIST_ENTRY_CNT(LIST_ENTRY_CNT)
	) u_fmt (
		.step, .entry_id, .ptr_arg, .free_head, .uncomp_tail,
		.addr(req_addr), .data(req_data), .strb(req_strb)
	);

	list_ptr_regs u_ptrs (
		.clk_i, .rst_ni, .free_set, .free_head_nxt, .free_tail_nxt,
		.uncomp_set, .uncomp_head_nxt, .uncomp_tail_nxt,
		.set_att_done, .set_list_done,
		.free_head, .free_tail, .uncomp_head, .uncomp_tail, .att_done, .list_done
	);

	axi_wr_port u_port (
		.clk_i, .rst_ni, .issue,
		.addr(req_addr), .data(req_data), .strb(req_strb),
		.awready, .wready, .bvalid, .bresp,
		.awvalid, .awaddr, .wvalid, .wdata, .wstrb,
		.wr_idle, .resp_idle, .bus_error
	);

endmodule

// ==== pgwr_mngr/pgwr_seq.sv ====
//--------------------------------------------------------------------------
// sequencer FSM: ATT and list initialisation loops, table update
// (alloc, pop from free list, push onto uncompressed list, response drain)
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module pgwr_seq #(
	parameter int ATT_ENTRY_CNT = 16,
	parameter int LIST_ENTRY_CNT = 8
) (
	input logic clk_i,
	input logic rst_ni,
	input logic init_att,
	input logic init_list,
	input logic upd_valid,
	input logic [pgwr_pkg::ID_W-1:0] upd_att_id,
	input logic [pgwr_pkg::ID_W-1:0] upd_next,
	input logic att_done,
	input logic list_done,
	input logic [pgwr_pkg::ID_W-1:0] free_head,
	input logic [pgwr_pkg::ID_W-1:0] free_tail,
	input logic [pgwr_pkg::ID_W-1:0] uncomp_tail,
	input logic wr_idle,
	input logic resp_idle,
	output logic upd_ready,
	output logic upd_done,
	output logic ready,
	output logic issue,
	output pgwr_pkg::step_e step,
	output logic [pgwr_pkg::ID_W-1:0] entry_id,
	output logic [pgwr_pkg::ID_W-1:0] ptr_arg,
	output logic set_att_done,
	output logic set_list_done,
	output logic free_set,
	output logic [pgwr_pkg::ID_W-1:0] free_head_nxt,
	output logic [pgwr_pkg::ID_W-1:0] free_tail_nxt,
	output logic uncomp_set,
	output logic [pgwr_pkg::ID_W-1:0] uncomp_head_nxt,
	output logic [pgwr_pkg::ID_W-1:0] uncomp_tail_nxt
);

	localparam logic [2:0] S_IDLE = 3'd0;
	localparam logic [2:0] S_ATT = 3'd1;    // ATT init loop
	localparam logic [2:0] S_LIST = 3'd2;   // list init loop
	localparam logic [2:0] S_ALLOC = 3'd3;
	localparam logic [2:0] S_POP = 3'd4;
	localparam logic [2:0] S_SELF = 3'd5;
	localparam logic [2:0] S_LINK = 3'd6;
	localparam logic [2:0] S_WAIT = 3'd7;   // drain write responses

	logic [2:0] state_q, state_d;
	logic [pgwr_pkg::ID_W-1:0] cnt_q, cnt_d;   // init entry id, from 1
	logic [pgwr_pkg::ID_W-1:0] att_id_q;
	logic [pgwr_pkg::ID_W-1:0] next_q;
	logic [pgwr_pkg::ID_W-1:0] push_id_q;      // free head at request time
	logic upd_take;

	assign ready = (state_q == S_IDLE);
	assign upd_ready = ready && att_done && list_done && (free_head != '0);
	assign upd_take = upd_valid && upd_ready;
	assign upd_done = (state_q == S_WAIT) && wr_idle && resp_idle;

	always_comb begin
		state_d = state_q;
		cnt_d = cnt_q;
		issue = 1'b0;
		step = pgwr_pkg::ATT_INIT;
		entry_id = cnt_q;
		ptr_arg = '0;
		set_att_done = 1'b0;
		set_list_done = 1'b0;
		free_set = 1'b0;
		free_head_nxt = next_q;   // pop moves head to old head's next
		free_tail_nxt = free_tail;
		uncomp_set = 1'b0;
		uncomp_head_nxt = push_id_q;
		uncomp_tail_nxt = push_id_q;
		case (state_q)
			S_IDLE: begin
				if (init_att && !att_done) begin   // ATT goes first
					state_d = S_ATT;
					cnt_d = 1;
				end else if (init_list && !list_done) begin
					state_d = S_LIST;
					cnt_d = 1;
				end else if (upd_take) begin
					state_d = S_ALLOC;
				end
			end
			S_ATT, S_LIST: begin
				if (wr_idle) begin
					if (cnt_q <= ((state_q == S_ATT) ? ATT_ENTRY_CNT : LIST_ENTRY_CNT)) begin
						issue = 1'b1;
						step = (state_q == S_ATT) ? pgwr_pkg::ATT_INIT : pgwr_pkg::LIST_INIT;
						cnt_d = cnt_q + 1'b1;
					end else if (state_q == S_ATT) begin
						set_att_done = 1'b1;
						state_d = S_IDLE;
					end else begin
						// all entries chained into one free list
						set_list_done = 1'b1;
						free_set = 1'b1;
						free_head_nxt = 1;
						free_tail_nxt = LIST_ENTRY_CNT;
						state_d = S_IDLE;
					end
				end
			end
			S_ALLOC: begin
				if (wr_idle) begin
					issue = 1'b1;
					step = pgwr_pkg::ATT_ALLOC;
					entry_id = att_id_q;
					state_d = S_POP;
				end
			end
			S_POP: begin
				if (wr_idle) begin
					free_set = 1'b1;
					if (free_head != free_tail) begin
						issue = 1'b1;
						step = pgwr_pkg::POP_FIX;
						entry_id = next_q;
					end else begin   // last free entry, list goes empty
						free_head_nxt = '0;
						free_tail_nxt = '0;
					end
					state_d = S_SELF;
				end
			end
			S_SELF: begin
				if (wr_idle) begin
					issue = 1'b1;
					step = pgwr_pkg::PUSH_SELF;
					entry_id = push_id_q;
					if (uncomp_tail == '0) begin   // empty list, no link write
						uncomp_set = 1'b1;
						state_d = S_WAIT;
					end else begin
						state_d = S_LINK;
					end
				end
			end
			S_LINK: begin
				if (wr_idle) begin
					issue = 1'b1;
					step = pgwr_pkg::PUSH_LINK;
					entry_id = uncomp_tail;
					ptr_arg = push_id_q;
					uncomp_set = 1'b1;
					state_d = S_WAIT;
				end
			end
			default: begin
				if (wr_idle && resp_idle) state_d = S_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q <= S_IDLE;
			cnt_q <= '0;
		end else begin
			state_q <= state_d;
			cnt_q <= cnt_d;
		end
	end

	// request payload, held for the whole update
	always_ff @(posedge clk_i) begin
		if (upd_take) begin
			att_id_q <= upd_att_id;
			next_q <= upd_next;
			push_id_q <= free_head;
		end
	end

	// a write only starts on an idle port, which then goes busy
	a_issue_on_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
		issue |-> wr_idle ##1 !wr_idle);

endmodule

// ==== pgwr_mngr/tbl_wr_fmt.sv ====
//--------------------------------------------------------------------------
// table write formatter: line address, lane data and byte strobes
// for each kind of ATT and list write
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module tbl_wr_fmt #(
	parameter int ATT_ENTRY_CNT = 16,
	parameter int LIST_ENTRY_CNT = 8
) (
	input pgwr_pkg::step_e step,
	input logic [pgwr_pkg::ID_W-1:0] entry_id,
	input logic [pgwr_pkg::ID_W-1:0] ptr_arg,
	input logic [pgwr_pkg::ID_W-1:0] free_head,     // id being pushed
	input logic [pgwr_pkg::ID_W-1:0] uncomp_tail,
	output logic [pgwr_pkg::ADDR_W-1:0] addr,
	output logic [pgwr_pkg::DATA_W-1:0] data,
	output logic [pgwr_pkg::STRB_W-1:0] strb
);

	// index widths, at least one line-select bit each
	localparam int ATT_IDX_W = (ATT_ENTRY_CNT > 16) ? $clog2(ATT_ENTRY_CNT) : 4;
	localparam int LIST_IDX_W = (LIST_ENTRY_CNT > 8) ? $clog2(LIST_ENTRY_CNT) : 3;

	logic [pgwr_pkg::ID_W-1:0] idx;   // zero based entry index
	logic [ATT_IDX_W-1:0] att_idx;
	logic [LIST_IDX_W-1:0] list_idx;
	logic [2:0] lane_sel;             // 8 ATT lanes per line
	logic [1:0] slot_sel;             // 4 list slots per line
	logic [pgwr_pkg::ADDR_W-1:0] att_addr;
	logic [pgwr_pkg::ADDR_W-1:0] list_addr;
	pgwr_pkg::tbl_lane_u lane;

	function automatic logic [45:0] way_of(input logic [pgwr_pkg::ID_W-1:0] id);
		return pgwr_pkg::PPA_BASE_PG + 46'(id) - 46'd1;
	endfunction

	assign idx = entry_id - 1'b1;
	assign att_idx = idx[ATT_IDX_W-1:0];
	assign list_idx = idx[LIST_IDX_W-1:0];
	assign lane_sel = att_idx[2:0];
	assign slot_sel = list_idx[1:0];

	// line base: 64 bytes per line
	assign att_addr = pgwr_pkg::ATT_BASE
		+ {{(pgwr_pkg::ADDR_W-ATT_IDX_W-3){1'b0}}, att_idx[ATT_IDX_W-1:3], 6'b0};
	assign list_addr = pgwr_pkg::LIST_BASE
		+ {{(pgwr_pkg::ADDR_W-LIST_IDX_W-4){1'b0}}, list_idx[LIST_IDX_W-1:2], 6'b0};

	always_comb begin
		lane = '0;
		data = '0;
		strb = '0;
		addr = list_addr;
		case (step)
			pgwr_pkg::ATT_INIT, pgwr_pkg::ATT_ALLOC: begin
				addr = att_addr;
				if (step == pgwr_pkg::ATT_ALLOC) begin   // page of the popped list entry
					lane.att.way = way_of(free_head);
					lane.att.sts = pgwr_pkg::UNCOMP;
				end else begin
					lane.att.sts = pgwr_pkg::DALLOC;
				end
				data[64*lane_sel +: 64] = lane;
				strb[8*lane_sel +: 8] = 8'hff;
			end
			pgwr_pkg::LIST_INIT: begin
				lane.ptr.prev = idx;   // entry 1 gets null
				lane.ptr.next = (entry_id == LIST_ENTRY_CNT) ? '0 : entry_id + 1'b1;
				data[128*slot_sel +: 64] = lane;
				data[128*slot_sel+64 +: 64] = {18'b0, way_of(entry_id)};
				strb[16*slot_sel +: 16] = 16'hffff;   // whole slot
			end
			pgwr_pkg::PUSH_SELF: begin
				lane.ptr.prev = uncomp_tail;
				lane.ptr.next = '0;
				data[128*slot_sel +: 64] = lane;
				strb[16*slot_sel +: 8] = 8'hff;
			end
			pgwr_pkg::POP_FIX: begin
				lane.ptr.prev = ptr_arg;
				data[128*slot_sel +: 64] = lane;
				strb[16*slot_sel+4 +: 4] = 4'hf;   // prev bytes only
			end
			pgwr_pkg::PUSH_LINK: begin
				lane.ptr.next = ptr_arg;
				data[128*slot_sel +: 64] = lane;
				strb[16*slot_sel +: 4] = 4'hf;     // next bytes only
			end
			default: begin
				strb = '0;
			end
		endcase
	end

endmodule

// ==== testbench/tb_pgwr_mngr.sv ====
//--------------------------------------------------------------------------
// testbench top with clock, reset, write slave, reference table model and
// directed tests for init, updates, bus error and free list drain
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module tb_pgwr_mngr;

	localparam int ATT_CNT = 16;
	localparam int LIST_CNT = 8;
	localparam int WAIT_MAX = 2000;   // cycles per wait loop

	logic clk_i;
	logic rst_ni;
	logic init_att;
	logic init_list;
	logic upd_valid;
	logic [pgwr_pkg::ID_W-1:0] upd_att_id;
	logic [pgwr_pkg::ID_W-1:0] upd_next;
	logic awready;
	logic wready;
	logic bvalid;
	logic [1:0] bresp;
	logic awvalid;
	logic [pgwr_pkg::ADDR_W-1:0] awaddr;
	logic wvalid;
	logic [pgwr_pkg::DATA_W-1:0] wdata;
	logic [pgwr_pkg::STRB_W-1:0] wstrb;
	logic upd_ready;
	logic upd_done;
	logic att_done;
	logic list_done;
	logic ready;
	logic bus_error;
	logic [pgwr_pkg::ID_W-1:0] free_head;
	logic [pgwr_pkg::ID_W-1:0] free_tail;
	logic [pgwr_pkg::ID_W-1:0] uncomp_head;
	logic [pgwr_pkg::ID_W-1:0] uncomp_tail;
	logic err_inject;

	logic [63:0] att_ref [1:ATT_CNT];    // expected ATT lanes
	logic [31:0] prev_ref [1:LIST_CNT];  // expected list pointers
	logic [31:0] next_ref [1:LIST_CNT];
	int free_q [$];     // free list with head first
	int uncomp_q [$];   // uncompressed list with head first

	pgwr_mngr #(
		.ATT_ENTRY_CNT(ATT_CNT),
		.LIST_ENTRY_CNT(LIST_CNT)
	) DUT (
		.clk_i, .rst_ni, .init_att, .init_list, .upd_valid, .upd_att_id, .upd_next,
		.awready, .wready, .bvalid, .bresp, .awvalid, .awaddr, .wvalid, .wdata, .wstrb,
		.upd_ready, .upd_done, .att_done, .list_done, .ready, .bus_error,
		.free_head, .free_tail, .uncomp_head, .uncomp_tail
	);

	tb_wr_slave u_slave (
		.clk_i, .rst_ni, .awvalid, .awaddr, .wvalid, .wdata, .wstrb,
		.err_inject, .awready, .wready, .bvalid, .bresp
	);

	always #5 clk_i = ~clk_i;   // 10 ns period

	task automatic stop_run();
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_val(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		assert (got == exp) else begin
			$display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
			stop_run();
		end
	endtask

	// inputs change just after the rising edge
	task automatic drive_slot();
		@(posedge clk_i);
		#1;
	endtask

	function automatic logic [45:0] page_way(input int k);
		return pgwr_pkg::PPA_BASE_PG + 46'(k - 1);   // entry k owns page base + k - 1
	endfunction

	// 8 ATT entries per line with one lane each
	function automatic logic [63:0] att_lane(input int id);
		logic [63:0] a;
		logic [pgwr_pkg::DATA_W-1:0] line;
		a = pgwr_pkg::ATT_BASE + 64'((id - 1) / 8 * 64);
		line = u_slave.line_at(a);
		return line[64 * ((id - 1) % 8) +: 64];
	endfunction

	// 4 list entries per line with two lanes each
	function automatic logic [63:0] list_lane(input int k, input int hi);
		logic [63:0] a;
		logic [pgwr_pkg::DATA_W-1:0] line;
		a = pgwr_pkg::LIST_BASE + 64'((k - 1) / 4 * 64);
		line = u_slave.line_at(a);
		return line[128 * ((k - 1) % 4) + 64 * hi +: 64];
	endfunction

	function automatic logic [31:0] entry_prev(input int k);
		logic [63:0] lo;
		lo = list_lane(k, 0);
		return lo[63:32];
	endfunction

	function automatic logic [31:0] entry_next(input int k);
		logic [63:0] lo;
		lo = list_lane(k, 0);
		return lo[31:0];
	endfunction

	task automatic check_att();
		int id;
		for (id = 1; id <= ATT_CNT; id++) begin
			check_val($sformatf("att lane %0d", id), att_lane(id), att_ref[id]);
		end
	endtask

	task automatic check_list();
		int k;
		for (k = 1; k <= LIST_CNT; k++) begin
			check_val($sformatf("entry %0d prev", k), 64'(entry_prev(k)), 64'(prev_ref[k]));
			check_val($sformatf("entry %0d next", k), 64'(entry_next(k)), 64'(next_ref[k]));
			check_val($sformatf("entry %0d way", k), list_lane(k, 1), {18'h0, page_way(k)});
		end
	endtask

	task automatic check_ptrs();
		int fh;
		int ft;
		int uh;
		int ut;
		fh = 0;
		ft = 0;
		uh = 0;
		ut = 0;
		if (free_q.size() > 0) begin
			fh = free_q[0];
			ft = free_q[$];
		end
		if (uncomp_q.size() > 0) begin
			uh = uncomp_q[0];
			ut = uncomp_q[$];
		end
		check_val("free_head", 64'(free_head), 64'(fh));
		check_val("free_tail", 64'(free_tail), 64'(ft));
		check_val("uncomp_head", 64'(uncomp_head), 64'(uh));
		check_val("uncomp_tail", 64'(uncomp_tail), 64'(ut));
	endtask

	task automatic check_reset();
		@(negedge clk_i);
		check_val("awvalid", 64'(awvalid), 64'h0);
		check_val("wvalid", 64'(wvalid), 64'h0);
		check_val("upd_done", 64'(upd_done), 64'h0);
		check_val("bus_error", 64'(bus_error), 64'h0);
		check_val("ready", 64'(ready), 64'h1);
		check_ptrs();   // both lists still empty
	endtask

	task automatic test_att_init();
		int cnt0;
		int t;
		int id;
		cnt0 = u_slave.wr_cnt;
		drive_slot();
		init_att = 1'b1;
		t = 0;
		do begin
			@(negedge clk_i);
			t++;
		end while (!att_done && t < WAIT_MAX);
		if (!att_done) begin
			$display("timeout waiting for the ATT initialisation to finish");
			stop_run();
		end
		drive_slot();
		init_att = 1'b0;
		check_val("ATT write count", 64'(u_slave.wr_cnt - cnt0), 64'(ATT_CNT));
		for (id = 1; id <= ATT_CNT; id++) att_ref[id] = 64'h0;   // DALLOC and way 0
		check_att();
	endtask

	task automatic test_list_init();
		int cnt0;
		int t;
		int k;
		cnt0 = u_slave.wr_cnt;
		drive_slot();
		init_list = 1'b1;
		t = 0;
		do begin
			@(negedge clk_i);
			t++;
		end while (!list_done && t < WAIT_MAX);
		if (!list_done) begin
			$display("timeout waiting for the list initialisation to finish");
			stop_run();
		end
		drive_slot();
		init_list = 1'b0;
		check_val("list write count", 64'(u_slave.wr_cnt - cnt0), 64'(LIST_CNT));
		for (k = 1; k <= LIST_CNT; k++) begin
			prev_ref[k] = 32'(k - 1);
			next_ref[k] = (k == LIST_CNT) ? 32'h0 : 32'(k + 1);
			free_q.push_back(k);
		end
		check_att();
		check_list();
		check_ptrs();
	endtask

	// one table update checked against the reference model
	task automatic run_update(input int att_id);
		int id;
		int nxt;
		int tail;
		int exp_wr;
		int cnt0;
		int t;
		id = free_q[0];
		nxt = (free_q.size() > 1) ? free_q[1] : 0;
		tail = (uncomp_q.size() > 0) ? uncomp_q[$] : 0;
		exp_wr = 2 + ((nxt != 0) ? 1 : 0) + ((tail != 0) ? 1 : 0);   // plus pop fix and link
		cnt0 = u_slave.wr_cnt;
		drive_slot();
		upd_valid = 1'b1;
		upd_att_id = 32'(att_id);
		upd_next = 32'(nxt);
		t = 0;
		do begin
			@(negedge clk_i);
			t++;
		end while (!upd_ready && t < WAIT_MAX);
		if (!upd_ready) begin
			$display("timeout: update for ATT id %0d was never accepted", att_id);
			stop_run();
		end
		drive_slot();   // request taken at this edge
		upd_valid = 1'b0;
		t = 0;
		do begin
			@(negedge clk_i);
			t++;
		end while (!upd_done && t < WAIT_MAX);
		if (!upd_done) begin
			$display("timeout: update for ATT id %0d never completed", att_id);
			stop_run();
		end
		check_val("update write count", 64'(u_slave.wr_cnt - cnt0), 64'(exp_wr));
		att_ref[att_id] = {16'h0, page_way(id), pgwr_pkg::UNCOMP};
		if (nxt != 0) prev_ref[nxt] = 32'h0;   // new free head
		prev_ref[id] = 32'(tail);
		next_ref[id] = 32'h0;
		if (tail != 0) next_ref[tail] = 32'(id);
		void'(free_q.pop_front());
		uncomp_q.push_back(id);
		check_att();
		check_list();
		check_ptrs();
	endtask

	task automatic test_first_update();
		run_update(5);
		check_val("att lane 5", att_lane(5), {16'h0, pgwr_pkg::PPA_BASE_PG, pgwr_pkg::UNCOMP});
		check_val("entry 2 prev", 64'(entry_prev(2)), 64'h0);
		check_val("entry 1 prev", 64'(entry_prev(1)), 64'h0);
		check_val("entry 1 next", 64'(entry_next(1)), 64'h0);
		check_val("free_head", 64'(free_head), 64'h2);
		check_val("uncomp_head", 64'(uncomp_head), 64'h1);
		check_val("uncomp_tail", 64'(uncomp_tail), 64'h1);
	endtask

	task automatic test_second_update();
		run_update(12);
		check_val("entry 1 next", 64'(entry_next(1)), 64'h2);
		check_val("entry 2 prev", 64'(entry_prev(2)), 64'h1);
		check_val("uncomp_head", 64'(uncomp_head), 64'h1);
		check_val("uncomp_tail", 64'(uncomp_tail), 64'h2);
	endtask

	task automatic test_bus_error();
		check_val("bus_error", 64'(bus_error), 64'h0);
		err_inject = 1'b1;   // every response of this update is SLVERR
		run_update(9);
		check_val("bus_error", 64'(bus_error), 64'h1);
		drive_slot();
		err_inject = 1'b0;
	endtask

	task automatic test_drain();
		int ids [5];
		int k;
		int t;
		int cnt0;
		ids = '{16, 1, 3, 7, 14};
		for (k = 0; k < 5; k++) begin
			if (free_q.size() == 1) begin   // last free entry is both head and tail
				check_val("free_head", 64'(free_head), 64'(free_q[0]));
				check_val("free_tail", 64'(free_tail), 64'(free_q[0]));
			end
			run_update(ids[k]);
		end
		check_val("free_head", 64'(free_head), 64'h0);
		check_val("free_tail", 64'(free_tail), 64'h0);
		// held request must not be taken on an empty free list
		cnt0 = u_slave.wr_cnt;
		drive_slot();
		upd_valid = 1'b1;
		upd_att_id = 32'd2;
		upd_next = 32'd0;
		for (t = 0; t < 20; t++) begin
			@(negedge clk_i);
			check_val("upd_ready", 64'(upd_ready), 64'h0);
		end
		drive_slot();
		upd_valid = 1'b0;
		check_val("write count after drain", 64'(u_slave.wr_cnt - cnt0), 64'h0);
		check_val("bus_error", 64'(bus_error), 64'h1);   // still sticky
	endtask

	initial begin
		clk_i = 1'b0;
		rst_ni = 1'b0;
		init_att = 1'b0;
		init_list = 1'b0;
		upd_valid = 1'b0;
		upd_att_id = '0;
		upd_next = '0;
		err_inject = 1'b0;
		repeat (3) @(posedge clk_i);
		#1;
		rst_ni = 1'b1;
		check_reset();
		test_att_init();
		test_list_init();
		test_first_update();
		test_second_update();
		test_bus_error();
		test_drain();
		$display("NO ERRORS");
		$finish;
	end

	// last resort against a stuck run
	initial begin
		#2000000;
		$display("simulation watchdog expired");
		stop_run();
	end

endmodule

// ==== testbench/tb_wr_slave.sv ====
//--------------------------------------------------------------------------
// write channel slave model: LFSR driven ready, delayed responses,
// sparse line memory merged under the byte strobes, write counter
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module tb_wr_slave (
	input logic clk_i,
	input logic rst_ni,
	input logic awvalid,
	input logic [pgwr_pkg::ADDR_W-1:0] awaddr,
	input logic wvalid,
	input logic [pgwr_pkg::DATA_W-1:0] wdata,
	input logic [pgwr_pkg::STRB_W-1:0] wstrb,
	input logic err_inject,                  // answer with SLVERR while high
	output logic awready,
	output logic wready,
	output logic bvalid,
	output logic [1:0] bresp
);

	logic [15:0] lfsr_q;
	logic [pgwr_pkg::ADDR_W-1:0] aw_addr_q;   // line of the write in flight
	logic [pgwr_pkg::DATA_W-1:0] mem [logic [pgwr_pkg::ADDR_W-1:0]];
	int resp_pend;   // responses not yet sent
	int wr_cnt;      // completed data beats

	// 16 bit Fibonacci, taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// unwritten bytes read back as a pattern of the line address
	function automatic logic [pgwr_pkg::DATA_W-1:0] fill_of(
		input logic [pgwr_pkg::ADDR_W-1:0] a
	);
		return {8{a ^ 64'h5a5a_c3c3_0f0f_9696}};
	endfunction

	function automatic logic [pgwr_pkg::DATA_W-1:0] line_at(
		input logic [pgwr_pkg::ADDR_W-1:0] a
	);
		if (mem.exists(a)) return mem[a];
		return fill_of(a);
	endfunction

	function automatic logic [pgwr_pkg::DATA_W-1:0] merge_line(
		input logic [pgwr_pkg::DATA_W-1:0] old_line,
		input logic [pgwr_pkg::DATA_W-1:0] new_data,
		input logic [pgwr_pkg::STRB_W-1:0] strb
	);
		logic [pgwr_pkg::DATA_W-1:0] line;
		int b;
		line = old_line;
		for (b = 0; b < pgwr_pkg::STRB_W; b++) begin
			if (strb[b]) line[8*b +: 8] = new_data[8*b +: 8];   // byte lane enabled
		end
		return line;
	endfunction

	initial begin
		awready = 1'b0;
		wready = 1'b0;
		bvalid = 1'b0;
		bresp = 2'b00;
		lfsr_q = 16'd79;   // seed
		aw_addr_q = '0;
		resp_pend = 0;
		wr_cnt = 0;
		forever begin
			@(posedge clk_i);
			// beats seen with the values of the closing cycle
			if (rst_ni && awvalid && awready) aw_addr_q = awaddr;
			if (rst_ni && wvalid && wready) begin
				mem[aw_addr_q] = merge_line(line_at(aw_addr_q), wdata, wstrb);
				wr_cnt++;
				resp_pend++;
			end
			#1;
			if (!rst_ni) begin
				awready = 1'b0;
				wready = 1'b0;
				bvalid = 1'b0;
				bresp = 2'b00;
			end else begin
				lfsr_q = lfsr_next(lfsr_q);
				awready = lfsr_q[0];
				lfsr_q = lfsr_next(lfsr_q);
				wready = lfsr_q[0];
				bvalid = 1'b0;   // single cycle response, no bready
				bresp = 2'b00;
				if (resp_pend > 0) begin
					lfsr_q = lfsr_next(lfsr_q);   // random response delay
					if (lfsr_q[0]) begin
						bvalid = 1'b1;
						bresp = err_inject ? 2'b10 : 2'b00;
						resp_pend--;
					end
				end
			end
		end
	end

endmodule
